/* src.f */
rtl/shader_pkg.sv
rtl/ray_id_pool.sv
rtl/ray_pixel_ram.sv
rtl/result_arbiter.sv
rtl/pixel_out_queue.sv
rtl/shader_unit.sv
verification/tb_shader_unit.sv

/* Makefile */
# Verilator flow for the shader unit testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  -f src.f --top-module tb_shader_unit -Mdir obj_dir -o sim_shader_unit

run: compile
	./obj_dir/sim_shader_unit | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/tb_shader_unit.sv */
module tb_shader_unit
  import shader_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 20000;

  logic clk = 1'b0;
  logic rst;
  int   seed;

  logic                  prg_valid;
  logic [pixel_id_w-1:0] prg_pixel_id;
  logic [coord_w-1:0]    prg_origin;
  logic [coord_w-1:0]    prg_dir;
  logic                  prg_stall;

  // result sources: 0 pcalc, 1 int, 2 sint, 3 ss
  logic [3:0]            src_valid;
  logic [ray_id_w-1:0]   src_ray [4];
  logic [tri_id_w-1:0]   pcalc_tri_id;
  logic [3:0]            src_stall;

  logic                  sint_out_valid;
  logic [ray_id_w-1:0]   sint_out_ray_id;
  logic                  sint_out_is_shadow;
  logic [coord_w-1:0]    sint_out_origin;
  logic [coord_w-1:0]    sint_out_dir;
  logic                  sint_out_stall;
  logic                  raystore_we;
  logic [ray_id_w-1:0]   raystore_addr;
  logic [coord_w-1:0]    raystore_origin;
  logic [coord_w-1:0]    raystore_dir;
  logic                  pb_we;
  logic [pixel_id_w-1:0] pb_pixel_id;
  logic [color_w-1:0]    pb_color;
  logic                  pb_full;

  // traffic control from the main sequence
  logic                  prg_on;
  int                    out_stall_mode;  // 0 off, 1 random, 2 held high
  logic                  pb_full_on;
  int                    launch_budget;
  int                    fixed_src;       // -1 picks sources at random
  logic [tri_id_w-1:0]   fixed_tri;

  // scoreboard
  logic [pixel_id_w-1:0]         pixel_of [num_rays];
  bit                            busy [num_rays];
  logic [ray_id_w-1:0]           outstanding_q [$];
  logic [pixel_id_w+color_w-1:0] expect_q [$];
  logic [pixel_id_w-1:0]         next_pixel;
  logic [ray_id_w-1:0]           last_issued;
  int issued_n;
  int returned_n;
  int written_n;
  int in_use = 0;
  int errors;
  int timeouts;

  shader_unit shader_unit_inst (
    .clk, .rst,
    .prg_valid, .prg_pixel_id, .prg_origin, .prg_dir, .prg_stall,
    .pcalc_valid(src_valid[0]), .pcalc_ray_id(src_ray[0]), .pcalc_tri_id,
    .pcalc_stall(src_stall[0]),
    .int_valid(src_valid[1]), .int_ray_id(src_ray[1]), .int_stall(src_stall[1]),
    .sint_valid(src_valid[2]), .sint_ray_id(src_ray[2]), .sint_stall(src_stall[2]),
    .ss_valid(src_valid[3]), .ss_ray_id(src_ray[3]), .ss_stall(src_stall[3]),
    .sint_out_valid, .sint_out_ray_id, .sint_out_is_shadow, .sint_out_origin,
    .sint_out_dir, .sint_out_stall,
    .raystore_we, .raystore_addr, .raystore_origin, .raystore_dir,
    .pb_we, .pb_pixel_id, .pb_color, .pb_full
  );

  always #20 clk = ~clk;

  task automatic report_error(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // pcalc and int hit, int means triangle 0, sint and ss miss
  function automatic logic [color_w-1:0] expected_color(input int src,
                                                        input logic [tri_id_w-1:0] tri_id);
    logic [color_w-1:0] c;
    if (src >= 2) c = miss_color;
    else if (src == 1 || tri_id == 16'd0) c = tri0_color;
    else if (tri_id == 16'd4) c = tri1_color;
    else c = hit_default_color;
    return c;
  endfunction

  // ------------------------------
  // monitor, sampled at the edge
  // ------------------------------
  task automatic observe();
    logic [ray_id_w-1:0] id;
    int delta;
    int hit;
    delta = 0;
    if (sint_out_valid && !sint_out_stall) begin
      id = sint_out_ray_id;
      a_issue_order: assert (issued_n >= num_rays || id == ray_id_w'(issued_n))
        else report_error($sformatf("ray id %0d issued, expected %0d", id, issued_n));
      a_issue_free: assert (!busy[id])
        else report_error($sformatf("ray id %0d issued while still in use", id));
      busy[id] = 1'b1;
      pixel_of[id] = prg_pixel_id;
      outstanding_q.push_back(id);
      last_issued = id;
      issued_n++;
      delta++;
    end
    for (int s = 0; s < 4; s++) begin
      if (src_valid[s] && !src_stall[s]) begin
        id = src_ray[s];
        busy[id] = 1'b0;
        expect_q.push_back({pixel_of[id], expected_color(s, pcalc_tri_id)});
        returned_n++;
        delta--;
      end
    end
    in_use <= in_use + delta;
    if (pb_we) begin
      hit = -1;
      for (int i = 0; i < expect_q.size(); i++) begin
        if (hit < 0 && expect_q[i] == {pb_pixel_id, pb_color}) hit = i;
      end
      a_pb_expected: assert (hit >= 0)
        else report_error($sformatf("pixel %0h colour %0h written with no result pending",
                                    pb_pixel_id, pb_color));
      if (hit >= 0) expect_q.delete(hit);
      written_n++;
    end
  endtask

  // ------------------------------
  // stimulus, 2 ns after the edge
  // ------------------------------
  task automatic drive(input bit prg_done, input logic [3:0] src_done);
    if (!prg_valid || prg_done) begin
      prg_valid = prg_on && chance(75);
      if (prg_valid) begin
        prg_pixel_id = next_pixel;
        next_pixel++;
        prg_origin = {$random(seed), $random(seed), $random(seed)};
        prg_dir = {$random(seed), $random(seed), $random(seed)};
      end
    end
    sint_out_stall = (out_stall_mode == 2) || (out_stall_mode == 1 && chance(25));
    pb_full = pb_full_on && chance(50);
    for (int s = 0; s < 4; s++) begin
      if (src_done[s]) src_valid[s] = 1'b0;
      if (!src_valid[s] && launch_budget > 0 && outstanding_q.size() > 0 &&
          (fixed_src == s || (fixed_src < 0 && chance(40)))) begin
        src_valid[s] = 1'b1;
        src_ray[s] = outstanding_q.pop_front();
        launch_budget--;
        // triangle 0, triangle 4 or anything else
        if (s == 0 && fixed_src == 0) pcalc_tri_id = fixed_tri;
        else if (s == 0) pcalc_tri_id = tri_id_w'(($unsigned($random(seed)) % 3) * 4);
      end
    end
  endtask

  always begin : bench_driver
    bit         prg_done;
    logic [3:0] src_done;
    @(posedge clk);
    prg_done = prg_valid && !prg_stall;
    src_done = src_valid & ~src_stall;
    if (!rst) observe();
    #2;
    if (!rst) drive(prg_done, src_done);
  end

  // kind 0 issues, 1 returns, 2 everything written back
  function automatic bit reached(input int kind, input int target);
    if (kind == 0) return issued_n >= target;
    if (kind == 1) return returned_n >= target;
    return src_valid == 4'h0 && expect_q.size() == 0;
  endfunction

  task automatic wait_until(input int kind, input int target, input string what);
    int n;
    n = 0;
    while (!reached(kind, target) && n < timeout_cycles && timeouts == 0) begin
      @(negedge clk);
      n++;
    end
    if (!reached(kind, target) && timeouts == 0) begin
      timeouts++;
      $display("Timeout at %0t ns while waiting for %s", $time, what);
    end
  endtask

  task automatic recycle_one(input int src, input logic [tri_id_w-1:0] tri_id);
    logic [ray_id_w-1:0] sent;
    sent = outstanding_q[0];
    fixed_src = src;
    fixed_tri = tri_id;
    launch_budget = 1;
    wait_until(0, issued_n + 1, "a returned ray id to be issued again");
    a_recycled_id: assert (last_issued == sent)
      else report_error($sformatf("issued id %0d after returning %0d", last_issued, sent));
    wait_until(2, 0, "the pixel buffer write of the returned ray");
  endtask

  // ------------------------------
  // concurrent checks
  // ------------------------------
  a_no_shadow: assert property (@(posedge clk) disable iff (rst) !sint_out_is_shadow)
    else report_error("sint_out_is_shadow was high");
  a_issue_copy: assert property (@(posedge clk) disable iff (rst)
    (sint_out_valid && !sint_out_stall) |-> sint_out_origin == prg_origin
      && sint_out_dir == prg_dir && raystore_we && raystore_addr == sint_out_ray_id
      && raystore_origin == prg_origin && raystore_dir == prg_dir)
    else report_error("issued ray and ray store write differ from the prg input");
  a_store_on_issue: assert property (@(posedge clk) disable iff (rst)
    raystore_we |-> sint_out_valid && !sint_out_stall)
    else report_error("ray store written without an issue");
  a_valid_from_prg: assert property (@(posedge clk) disable iff (rst)
    sint_out_valid |-> prg_valid)
    else report_error("sint_out_valid high without prg_valid");
  a_prg_matches_issue: assert property (@(posedge clk) disable iff (rst)
    (prg_valid && !prg_stall) == (sint_out_valid && !sint_out_stall))
    else report_error("prg transfer and ray issue disagree");
  a_stall_passes: assert property (@(posedge clk) disable iff (rst)
    sint_out_stall |-> prg_stall)
    else report_error("prg_stall low while sint_out_stall high");
  a_pool_dry: assert property (@(posedge clk) disable iff (rst)
    (in_use == num_rays) |-> prg_stall && !sint_out_valid)
    else report_error("issue possible with all ray ids in use");
  a_pb_full: assert property (@(posedge clk) disable iff (rst) pb_we |-> !pb_full)
    else report_error("pb_we high while pb_full high");

  initial begin : main_sequence
    int mark;
    seed = 32'h401c;
    rst = 1'b1;
    prg_valid = 1'b0;
    prg_pixel_id = '0;
    prg_origin = '0;
    prg_dir = '0;
    src_valid = 4'h0;
    for (int s = 0; s < 4; s++) src_ray[s] = '0;
    pcalc_tri_id = '0;
    sint_out_stall = 1'b0;
    pb_full = 1'b0;
    prg_on = 1'b0;
    out_stall_mode = 0;
    pb_full_on = 1'b0;
    launch_budget = 0;
    fixed_src = -1;
    fixed_tri = '0;
    for (int i = 0; i < num_rays; i++) busy[i] = 1'b0;
    next_pixel = 19'h00100;
    issued_n = 0;
    returned_n = 0;
    written_n = 0;
    errors = 0;
    timeouts = 0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);

    // ids in order under random back-pressure, then a held stall
    prg_on = 1'b1;
    out_stall_mode = 1;
    wait_until(0, 200, "the first 200 ray ids to issue");
    out_stall_mode = 2;
    repeat (2) @(negedge clk);
    mark = issued_n;
    repeat (40) @(negedge clk);
    a_held_no_issue: assert (issued_n == mark)
      else report_error("ray issued while sint_out_stall was held high");
    out_stall_mode = 1;
    wait_until(0, num_rays, "all ray ids to issue");

    // pool empty, results return one at a time
    out_stall_mode = 0;
    repeat (30) @(negedge clk);
    a_pool_stays_empty: assert (issued_n == num_rays)
      else report_error($sformatf("%0d rays issued from a pool of 512", issued_n));
    recycle_one(0, 16'd0);
    recycle_one(0, 16'd4);
    recycle_one(0, 16'd9);
    recycle_one(1, 16'd0);
    recycle_one(2, 16'd0);
    recycle_one(3, 16'd0);

    // mixed traffic with random pb_full
    fixed_src = -1;
    pb_full_on = 1'b1;
    out_stall_mode = 1;
    mark = returned_n;
    launch_budget = 1500;
    wait_until(1, mark + 1500, "1500 more results to be accepted");
    prg_on = 1'b0;
    wait_until(2, 0, "the pixel buffer writes of all results");
    a_one_write_each: assert (written_n == returned_n)
      else report_error($sformatf("%0d pixel writes for %0d results", written_n, returned_n));

    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* rtl/shader_unit.sv */
module shader_unit
  import shader_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // primary rays from the ray generator
  input  logic                  prg_valid,
  input  logic [pixel_id_w-1:0] prg_pixel_id,
  input  logic [coord_w-1:0]    prg_origin,
  input  logic [coord_w-1:0]    prg_dir,
  output logic                  prg_stall,

  // finished rays
  input  logic                  pcalc_valid,
  input  logic [ray_id_w-1:0]   pcalc_ray_id,
  input  logic [tri_id_w-1:0]   pcalc_tri_id,
  output logic                  pcalc_stall,
  input  logic                  int_valid,
  input  logic [ray_id_w-1:0]   int_ray_id,
  output logic                  int_stall,
  input  logic                  sint_valid,
  input  logic [ray_id_w-1:0]   sint_ray_id,
  output logic                  sint_stall,
  input  logic                  ss_valid,
  input  logic [ray_id_w-1:0]   ss_ray_id,
  output logic                  ss_stall,

  // rays to scene intersection
  output logic                  sint_out_valid,
  output logic [ray_id_w-1:0]   sint_out_ray_id,
  output logic                  sint_out_is_shadow,
  output logic [coord_w-1:0]    sint_out_origin,
  output logic [coord_w-1:0]    sint_out_dir,
  input  logic                  sint_out_stall,

  // ray store, write only
  output logic                  raystore_we,
  output logic [ray_id_w-1:0]   raystore_addr,
  output logic [coord_w-1:0]    raystore_origin,
  output logic [coord_w-1:0]    raystore_dir,

  // pixel buffer
  output logic                  pb_we,
  output logic [pixel_id_w-1:0] pb_pixel_id,
  output logic [color_w-1:0]    pb_color,
  input  logic                  pb_full
);

  logic [ray_id_w-1:0]   head_id;
  logic                  pool_empty;
  logic                  pool_init;
  logic                  issue;
  logic [3:0]            arb_in_stall;
  logic                  arb_valid;
  logic [ray_id_w-1:0]   arb_ray_id;
  logic [tri_id_w-1:0]   arb_tri_id;
  logic                  arb_is_hit;
  logic                  arb_stall;
  logic                  arb_accept;
  logic [pixel_id_w-1:0] ram_pixel_id;
  logic                  rd_valid;
  logic [tri_id_w-1:0]   rd_tri_id;
  logic                  rd_is_hit;
  logic                  q_room;

  // ------------------------------
  // issue path
  // ------------------------------
  assign prg_stall      = sint_out_stall | pool_empty;
  assign sint_out_valid = prg_valid & ~pool_empty;
  assign issue          = prg_valid & ~prg_stall;

  assign sint_out_ray_id    = head_id;
  assign sint_out_is_shadow = 1'b0;
  assign sint_out_origin    = prg_origin;
  assign sint_out_dir       = prg_dir;

  // store never stalls, written on the transfer cycle
  assign raystore_we     = issue;
  assign raystore_addr   = head_id;
  assign raystore_origin = prg_origin;
  assign raystore_dir    = prg_dir;

  // ------------------------------
  // result path
  // ------------------------------
  assign arb_stall  = pool_init | ~q_room;
  assign arb_accept = arb_valid & ~arb_stall;

  assign pcalc_stall = arb_in_stall[0];
  assign int_stall   = arb_in_stall[1];
  assign sint_stall  = arb_in_stall[2];
  assign ss_stall    = arb_in_stall[3];

  // tri id and hit flag ride alongside the ram read
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= arb_accept;
    end
  end

  always_ff @(posedge clk) begin
    rd_tri_id <= arb_tri_id;
    rd_is_hit <= arb_is_hit;
  end

  ray_id_pool ray_id_pool_inst (
    .clk, .rst,
    .push(arb_accept), .push_id(arb_ray_id), .pop(issue),
    .head_id, .empty(pool_empty), .initialising(pool_init)
  );

  ray_pixel_ram ray_pixel_ram_inst (
    .clk, .we(issue), .waddr(head_id), .wdata(prg_pixel_id),
    .raddr(arb_ray_id), .rdata(ram_pixel_id)
  );

  result_arbiter result_arbiter_inst (
    .clk, .rst,
    .in_valid({ss_valid, sint_valid, int_valid, pcalc_valid}),
    .in_ray_id({ss_ray_id, sint_ray_id, int_ray_id, pcalc_ray_id}),
    .in_tri_id(pcalc_tri_id), .out_stall(arb_stall), .in_stall(arb_in_stall),
    .out_valid(arb_valid), .out_ray_id(arb_ray_id),
    .out_tri_id(arb_tri_id), .out_is_hit(arb_is_hit)
  );

  pixel_out_queue pixel_out_queue_inst (
    .clk, .rst,
    .in_valid(rd_valid), .in_pixel_id(ram_pixel_id),
    .in_tri_id(rd_tri_id), .in_is_hit(rd_is_hit), .pb_full,
    .room(q_room), .pb_we, .pb_pixel_id, .pb_color
  );

endmodule

/* rtl/pixel_out_queue.sv */
module pixel_out_queue
  import shader_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic [pixel_id_w-1:0] in_pixel_id,
  input  logic [tri_id_w-1:0]   in_tri_id,
  input  logic                  in_is_hit,
  input  logic                  pb_full,
  output logic                  room,
  output logic                  pb_we,
  output logic [pixel_id_w-1:0] pb_pixel_id,
  output logic [color_w-1:0]    pb_color
);

  logic [pixel_id_w-1:0] pix_mem [out_queue_depth];
  logic [tri_id_w-1:0]   tri_mem [out_queue_depth];
  logic                  hit_mem [out_queue_depth];

  logic [$clog2(out_queue_depth)-1:0]   wr_ptr;
  logic [$clog2(out_queue_depth)-1:0]   rd_ptr;
  logic [$clog2(out_queue_depth+1)-1:0] count;
  logic                                 empty;
  logic                                 full;
  logic                                 rd_en;

  assign empty = (count == '0);
  assign full  = (count == out_queue_depth);

  // leave space for the entry already on its way from the ram
  assign room = (count + in_valid) < out_queue_depth;

  // ------------------------------
  // read side, pixel buffer
  // ------------------------------
  assign rd_en       = ~empty & ~pb_full;
  assign pb_we       = rd_en;
  assign pb_pixel_id = pix_mem[rd_ptr];
  assign pb_color    = calc_color(hit_mem[rd_ptr], tri_mem[rd_ptr]);

  always_ff @(posedge clk) begin
    if (in_valid) begin
      pix_mem[wr_ptr] <= in_pixel_id;
      tri_mem[wr_ptr] <= in_tri_id;
      hit_mem[wr_ptr] <= in_is_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == out_queue_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == out_queue_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + in_valid - rd_en;
    end
  end

  // room must have held back the arbiter in time
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) in_valid |-> !full);

endmodule

/* rtl/result_arbiter.sv */
module result_arbiter
  import shader_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [3:0]               in_valid,
  input  logic [3:0][ray_id_w-1:0] in_ray_id,
  input  logic [tri_id_w-1:0]      in_tri_id,
  input  logic                     out_stall,
  output logic [3:0]               in_stall,
  output logic                     out_valid,
  output logic [ray_id_w-1:0]      out_ray_id,
  output logic [tri_id_w-1:0]      out_tri_id,
  output logic                     out_is_hit
);

  // sources: 0 pcalc, 1 int, 2 sint, 3 ss
  logic [1:0] last;
  logic [1:0] win;
  logic [1:0] idx;
  logic [3:0] grant;
  logic       found;
  logic       load;

  // slot takes a new entry when empty or draining this cycle
  assign load = ~out_valid | ~out_stall;

  // round robin, search starts just after the last winner
  always_comb begin
    grant = '0;
    win   = last;
    found = 1'b0;
    for (int off = 1; off <= 4; off++) begin
      idx = last + 2'(off);
      if (!found && in_valid[idx]) begin
        grant[idx] = 1'b1;
        win        = idx;
        found      = 1'b1;
      end
    end
  end

  assign in_stall = load ? (in_valid & ~grant) : 4'hf;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      last      <= 2'd3;
    end else if (load) begin
      out_valid <= found;
      if (found) last <= win;
    end
  end

  // pcalc and int are hits, int counts as triangle 0
  always_ff @(posedge clk) begin
    if (load && found) begin
      out_ray_id <= in_ray_id[win];
      out_is_hit <= (win[1] == 1'b0);
      out_tri_id <= (win == 2'd0) ? in_tri_id : '0;
    end
  end

  // last winner never wins again while another source waits
  a_round_robin: assert property (@(posedge clk) disable iff (rst)
    (load && found && |(in_valid & ~(4'b0001 << last))) |-> win != last);

endmodule

/* rtl/ray_pixel_ram.sv */
module ray_pixel_ram
  import shader_pkg::*;
(
  input  logic                  clk,
  input  logic                  we,
  input  logic [ray_id_w-1:0]   waddr,
  input  logic [pixel_id_w-1:0] wdata,
  input  logic [ray_id_w-1:0]   raddr,
  output logic [pixel_id_w-1:0] rdata
);

  // one pixel id per ray id
  logic [pixel_id_w-1:0] mem [num_rays];

  // ------------------------------
  // write port, issue side
  // ------------------------------
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // ------------------------------
  // read port, result side
  // ------------------------------
  // registered, one cycle behind raddr
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* rtl/ray_id_pool.sv */
module ray_id_pool
  import shader_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  logic [ray_id_w-1:0] push_id,
  input  logic                pop,
  output logic [ray_id_w-1:0] head_id,
  output logic                empty,
  output logic                initialising
);

  logic [ray_id_w-1:0] mem [num_rays];
  logic [ray_id_w-1:0] wr_ptr;
  logic [ray_id_w-1:0] rd_ptr;
  logic [ray_id_w:0]   count;
  logic [ray_id_w-1:0] init_cnt;
  logic                full;
  logic                wr_en;
  logic [ray_id_w-1:0] wr_data;

  assign empty = (count == '0);
  assign full  = (count == (ray_id_w+1)'(num_rays));

  // fill with 0..num_rays-1 first, returned ids only afterwards
  assign wr_en   = initialising | push;
  assign wr_data = initialising ? init_cnt : push_id;

  // first word fall through
  assign head_id = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      init_cnt     <= '0;
      initialising <= 1'b1;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (pop)   rd_ptr <= rd_ptr + 1'b1;
      count <= count + wr_en - pop;
      if (initialising) begin
        init_cnt <= init_cnt + 1'b1;
        if (init_cnt == ray_id_w'(num_rays - 1)) initialising <= 1'b0;
      end
    end
  end

  // issue side must respect empty, result side can never overfill
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);

endmodule

/* rtl/shader_pkg.sv */
package shader_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int ray_id_w   = 9;
  localparam int num_rays   = 512;
  localparam int pixel_id_w = 19;
  localparam int tri_id_w   = 16;

  // origin or direction, three 32-bit components
  localparam int coord_w    = 96;
  localparam int color_w    = 24;

  // output fifo toward the pixel buffer
  localparam int out_queue_depth = 4;

  // ------------------------------
  // colour table
  // ------------------------------
  localparam logic [color_w-1:0] miss_color        = 24'h101830;
  localparam logic [color_w-1:0] tri0_color        = 24'hd02020;
  localparam logic [color_w-1:0] tri1_color        = 24'h20c040;
  localparam logic [color_w-1:0] hit_default_color = 24'h8080f0;

  // triangle ids with their own colour
  localparam logic [tri_id_w-1:0] tri0_id = 16'h0000;
  localparam logic [tri_id_w-1:0] tri1_id = 16'h0004;

  // stand-in for real shading
  function automatic logic [color_w-1:0] calc_color(
    input logic                is_hit,
    input logic [tri_id_w-1:0] tri_id
  );
    logic [color_w-1:0] color;
    if (!is_hit) begin
      color = miss_color;
    end else if (tri_id == tri0_id) begin
      color = tri0_color;
    end else if (tri_id == tri1_id) begin
      color = tri1_color;
    end else begin
      color = hit_default_color;
    end
    return color;
  endfunction

endpackage
